//--- red_pkg.sv
// Reduction stage shared definitions
// Route count, payload widths, collective encodings and flit layout

`default_nettype none

package red_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------

  // Input routes merged into the one output port
  localparam int unsigned num_routes = 4;

  // Payload word carried by every flit
  localparam int unsigned data_width = 32;

  // Index over the input routes
  typedef logic [$clog2(num_routes)-1:0] route_idx_t;

  // One bit per route, set for every member of a collective
  typedef logic [num_routes-1:0] route_mask_t;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------

  // Collective operation requested by the flit header
  typedef enum logic [1:0] {
    op_forward   = 2'd0,
    op_lsb_and   = 2'd1,
    op_collect_b = 2'd2
  } collect_op_e;

  // AXI write response code
  typedef logic [1:0] resp_t;

  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10;

  // ----------------------------------------
  // Flit layout
  // ----------------------------------------

  // Header, 10 bits
  typedef struct packed {
    collect_op_e collective_op;
    route_mask_t route_mask;
    logic [3:0]  src_id;
  } flit_hdr_t;

  // B response view, resp sits in the low bits of the word
  typedef struct packed {
    logic [data_width-3:0] reserved;
    resp_t                 resp;
  } b_view_t;

  // Payload word, read as W data or as a B response
  typedef union packed {
    logic [data_width-1:0] w_data;
    b_view_t               b_view;
  } flit_payload_u;

  // Full flit, header in the upper bits
  typedef struct packed {
    flit_hdr_t     hdr;
    flit_payload_u payload;
  } flit_t;

  // Flit size in bits, 42
  localparam int unsigned flit_width = $bits(flit_t);

endpackage

`default_nettype wire

//--- reduction_sync.sv
// Group synchroniser for one input lane
// Flags when the collective led by this lane has all its members present

`timescale 1ns/1ps
`default_nettype none

module reduction_sync (
  // Lane this instance watches
  input  red_pkg::route_idx_t                        sel_i,
  // All input lanes
  input  logic [red_pkg::num_routes-1:0]             valid_i,
  input  red_pkg::flit_t [red_pkg::num_routes-1:0]   data_i,
  // Downstream ready
  input  logic                                       ready_i,
  // Group status
  output logic                                       valid_o,
  output logic [red_pkg::num_routes-1:0]             ready_o,
  output red_pkg::route_mask_t                       route_mask_o
);

  import red_pkg::*;

  // Route mask carried by the watched lane
  route_mask_t own_mask;

  // Partial checks over the members
  logic below_clear;
  logic members_valid;
  logic masks_equal;
  logic is_lead;

  assign own_mask = data_i[sel_i].hdr.route_mask;

  // Walk every lane named in the mask
  always_comb begin
    below_clear   = 1'b1;
    members_valid = 1'b1;
    masks_equal   = 1'b1;
    for (int i = 0; i < num_routes; i++) begin
      if (own_mask[i]) begin
        // A member below us means we are not the lead
        if (i < int'(sel_i)) begin
          below_clear = 1'b0;
        end
        // Every member has to be waiting
        if (!valid_i[i]) begin
          members_valid = 1'b0;
        end
        // and has to agree on who takes part
        if (data_i[i].hdr.route_mask != own_mask) begin
          masks_equal = 1'b0;
        end
      end
    end
  end

  // Lead lane is valid and is the lowest set bit of its own mask
  assign is_lead = valid_i[sel_i] & own_mask[sel_i] & below_clear;

  // Group complete
  assign valid_o = is_lead & members_valid & masks_equal;

  // Release all members together, only for a complete group
  assign ready_o = (valid_o && ready_i) ? own_mask : '0;

  assign route_mask_o = own_mask;

endmodule

`default_nettype wire

//--- reduction_arbiter.sv
// Reduction arbiter for the output port
// Picks the lowest complete group and merges it into one flit

`timescale 1ns/1ps
`default_nettype none

module reduction_arbiter (
  // Input lanes
  input  logic [red_pkg::num_routes-1:0]             valid_i,
  output logic [red_pkg::num_routes-1:0]             ready_o,
  input  red_pkg::flit_t [red_pkg::num_routes-1:0]   data_i,
  // Merged output
  output logic                                       valid_o,
  input  logic                                       ready_i,
  output red_pkg::flit_t                             data_o
);

  import red_pkg::*;

  // Per-lead group status from the sync instances
  logic        [num_routes-1:0]                 grp_valid;
  logic        [num_routes-1:0][num_routes-1:0] grp_ready;
  route_mask_t [num_routes-1:0]                 grp_mask;

  // Selected lead and its view of the group
  route_idx_t  input_sel;
  route_mask_t sel_mask;
  collect_op_e sel_op;

  // Results of the three reductions, built side by side
  flit_t data_forward;
  flit_t data_lsb_and;
  flit_t data_collect_b;

  // Scratch for the reductions
  logic lsb_acc;
  logic err_found;

  // ----------------------------------------
  // Group detection
  // ----------------------------------------

  for (genvar g = 0; g < num_routes; g++) begin : gen_sync
    reduction_sync reduction_sync_i (
      .sel_i        (route_idx_t'(g)),
      .valid_i      (valid_i),
      .data_i       (data_i),
      .ready_i      (ready_i),
      .valid_o      (grp_valid[g]),
      .ready_o      (grp_ready[g]),
      .route_mask_o (grp_mask[g])
    );
  end

  // Trailing-one search, lowest complete lead wins
  always_comb begin
    input_sel = '0;
    for (int i = num_routes - 1; i >= 0; i--) begin
      if (grp_valid[i]) begin
        input_sel = route_idx_t'(i);
      end
    end
  end

  assign sel_mask = grp_mask[input_sel];
  assign sel_op   = data_i[input_sel].hdr.collective_op;

  // ----------------------------------------
  // Reductions
  // ----------------------------------------

  // Forward the lead flit as it is
  assign data_forward = data_i[input_sel];

  // AND of bit 0 over all members, written back into the lead flit
  always_comb begin
    lsb_acc = 1'b1;
    for (int i = 0; i < num_routes; i++) begin
      if (sel_mask[i]) begin
        lsb_acc = lsb_acc & data_i[i].payload.w_data[0];
      end
    end
    data_lsb_and                   = data_i[input_sel];
    data_lsb_and.payload.w_data[0] = lsb_acc;
  end

  // First member reporting a slave error, else the lead
  always_comb begin
    data_collect_b = data_i[input_sel];
    err_found      = 1'b0;
    for (int i = 0; i < num_routes; i++) begin
      if (sel_mask[i] && !err_found) begin
        if (data_i[i].payload.b_view.resp == resp_slverr) begin
          data_collect_b = data_i[i];
          err_found      = 1'b1;
        end
      end
    end
  end

  // Lead header picks the result
  always_comb begin
    case (sel_op)
      op_lsb_and:   data_o = data_lsb_and;
      op_collect_b: data_o = data_collect_b;
      default:      data_o = data_forward;
    endcase
  end

  // ----------------------------------------
  // Handshake
  // ----------------------------------------

  // Only the chosen group sees the downstream ready
  assign ready_o = grp_ready[input_sel];
  assign valid_o = grp_valid[input_sel];

endmodule

`default_nettype wire

//--- reduction_out_reg.sv
// Output register stage
// One flit deep, full throughput valid/ready handshake

`timescale 1ns/1ps
`default_nettype none

module reduction_out_reg (
  input  logic           clk_i,
  input  logic           rst_n_i,
  // Upstream side
  input  logic           valid_i,
  output logic           ready_o,
  input  red_pkg::flit_t data_i,
  // Downstream side
  output logic           valid_o,
  input  logic           ready_i,
  output red_pkg::flit_t data_o
);

  import red_pkg::*;

  // Occupancy flag
  logic full_q;

  // Stored flit
  logic [flit_width-1:0] data_q;

  // Accept when empty or when the held flit leaves this cycle
  assign ready_o = ~full_q | ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      full_q <= valid_i;
    end
  end

  // Payload loads on an accepted transfer only
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = full_q;
  assign data_o  = flit_t'(data_q);

endmodule

`default_nettype wire

//--- reduction_unit.sv
// Reduction unit top level
// Arbiter merges collective groups, register stage absorbs back-pressure

`timescale 1ns/1ps
`default_nettype none

module reduction_unit (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  // Input lanes
  input  logic [red_pkg::num_routes-1:0]             valid_i,
  output logic [red_pkg::num_routes-1:0]             ready_o,
  input  red_pkg::flit_t [red_pkg::num_routes-1:0]   data_i,
  // Output port
  output logic                                       valid_o,
  input  logic                                       ready_i,
  output red_pkg::flit_t                             data_o
);

  import red_pkg::*;

  // ----------------------------------------
  // Arbiter to register stage
  // ----------------------------------------

  logic  arb_valid;
  logic  arb_ready;
  flit_t arb_data;

  // Combinational merge of the lowest complete group
  reduction_arbiter reduction_arbiter_i (
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_i  (data_i),
    .valid_o (arb_valid),
    .ready_i (arb_ready),
    .data_o  (arb_data)
  );

  // One cycle to the output, one group per cycle
  reduction_out_reg reduction_out_reg_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (arb_valid),
    .ready_o (arb_ready),
    .data_i  (arb_data),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (data_o)
  );

endmodule

`default_nettype wire

//--- tb_reduction_unit.sv
// Testbench for the reduction unit
// Offers groups of collective flits and checks the merged output stream

`timescale 1ns/1ps
`default_nettype none

module tb_reduction_unit;

  import red_pkg::*;

  // ----------------------------------------
  // Run length
  // ----------------------------------------

  localparam int reset_cycles    = 16;
  localparam int directed_rounds = 6;
  localparam int random_rounds   = 42;
  localparam int num_rounds      = directed_rounds + random_rounds;

  // Longest wait for the last flits to leave
  localparam int drain_cycles_max = 40;

  logic                        clk;
  logic                        rst_n;
  logic [num_routes-1:0]       in_valid;
  logic [num_routes-1:0]       in_ready;
  flit_t [num_routes-1:0]      in_data;
  logic                        out_valid;
  logic                        out_ready;
  flit_t                       out_data;

  // Group layout of the current round, per lane
  route_mask_t lane_mask [num_routes];
  collect_op_e lane_op [num_routes];

  // Expected flits in output order
  flit_t exp_q [$];

  logic [31:0] rng_state = 32'd94;
  logic        random_ready = 1'b0;

  // Output hold tracking for the monitor
  logic  stall_q = 1'b0;
  flit_t held_data;

  // A group left the inputs on the last edge
  logic  group_taken_q = 1'b0;

  int drain_cycles;

  reduction_unit reduction_unit_i (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .valid_i (in_valid),
    .ready_o (in_ready),
    .data_i  (in_data),
    .valid_o (out_valid),
    .ready_i (out_ready),
    .data_o  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // 32-bit xorshift step
  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Index of the lowest lane named in a mask
  function automatic int lowest_lane(input route_mask_t m);
    int k;
    k = 0;
    while (k < num_routes - 1 && !m[k]) begin
      k++;
    end
    return k;
  endfunction

  // Expected merge of one group
  function automatic flit_t reduce_ref(input flit_t [num_routes-1:0] flits,
                                       input route_mask_t mask);
    int    lead;
    logic  lsb;
    flit_t res;
    lead = lowest_lane(mask);
    res  = flits[lead];
    case (flits[lead].hdr.collective_op)
      op_lsb_and: begin
        lsb = 1'b1;
        for (int i = 0; i < num_routes; i++) begin
          if (mask[i]) begin
            lsb = lsb & flits[i].payload.w_data[0];
          end
        end
        res.payload.w_data[0] = lsb;
      end
      op_collect_b: begin
        // Scan downwards so the lowest erroring member is kept last
        for (int i = num_routes - 1; i >= 0; i--) begin
          if (mask[i] && flits[i].payload.b_view.resp == resp_slverr) begin
            res = flits[i];
          end
        end
      end
      default: begin
      end
    endcase
    return res;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  task automatic assign_group(input route_mask_t m, input collect_op_e op);
    for (int i = 0; i < num_routes; i++) begin
      if (m[i]) begin
        lane_mask[i] = m;
        lane_op[i]   = op;
      end
    end
  endtask

  // Random partition of the lanes into disjoint groups
  task automatic pick_random_groups();
    route_mask_t remaining;
    route_mask_t m;
    logic [31:0] r;
    int          lead;
    remaining = '1;
    while (remaining != '0) begin
      lead    = lowest_lane(remaining);
      r       = next_rand();
      m       = r[3:0] & remaining;
      m[lead] = 1'b1;
      r       = next_rand() % 32'd3;
      assign_group(m, collect_op_e'(r[1:0]));
      remaining = remaining & ~m;
    end
  endtask

  task automatic drive_ready();
    logic [31:0] r;
    r = next_rand();
    if (random_ready) begin
      out_ready <= (r[1:0] != 2'b00);
    end else begin
      out_ready <= 1'b1;
    end
  endtask

  // ----------------------------------------
  // One round of groups on all four lanes
  // ----------------------------------------

  task automatic run_round();
    flit_t [num_routes-1:0] flits;
    logic [31:0]            r;
    logic [num_routes-1:0]  pending;
    logic [num_routes-1:0]  taken;
    int                     low;
    for (int i = 0; i < num_routes; i++) begin
      flits[i].hdr.collective_op = lane_op[i];
      flits[i].hdr.route_mask    = lane_mask[i];
      flits[i].hdr.src_id        = 4'(i);
      flits[i].payload.w_data    = next_rand();
      if (lane_op[i] == op_collect_b) begin
        r = next_rand();
        flits[i].payload.b_view.resp = (r[1:0] == 2'b00) ? resp_slverr : resp_okay;
      end
    end
    // Expected flits go in by lead index
    for (int i = 0; i < num_routes; i++) begin
      if (lowest_lane(lane_mask[i]) == i) begin
        exp_q.push_back(reduce_ref(flits, lane_mask[i]));
      end
    end
    in_data  <= flits;
    in_valid <= '1;
    pending = '1;
    while (pending != '0) begin
      @(posedge clk);
      taken = in_valid & in_ready;
      check_value("in_ready on idle lanes", 64'(in_ready & ~in_valid), 64'd0);
      if (out_valid && !out_ready) begin
        check_value("in_ready under back-pressure", 64'(in_ready), 64'd0);
      end
      if (taken != '0) begin
        // A whole group leaves in one cycle
        low = lowest_lane(taken);
        check_value("in_ready group", 64'(taken), 64'(lane_mask[low]));
        pending = pending & ~taken;
      end
      in_valid <= pending;
      drive_ready();
    end
  endtask

  // ----------------------------------------
  // Output monitor
  // ----------------------------------------

  always @(posedge clk) begin
    if (rst_n) begin
      if (stall_q) begin
        check_value("out_valid held", 64'(out_valid), 64'd1);
        check_value("out_data held", 64'(out_data), 64'(held_data));
      end
      // One cycle from the inputs to the output port
      if (group_taken_q) begin
        check_value("out_valid after group", 64'(out_valid), 64'd1);
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Output flit %h arrived with no flit expected", out_data);
          $display(">>> FAIL");
          $fatal(1);
        end else begin
          check_value("out_data", 64'(out_data), 64'(exp_q.pop_front()));
        end
      end
      stall_q       = out_valid && !out_ready;
      held_data     = out_data;
      group_taken_q = |(in_valid & in_ready);
    end
  end

  // Watchdog, 40 cycles per round on top of reset
  initial begin
    repeat (reset_cycles + num_rounds * 40) @(posedge clk);
    $display("Timeout: test did not finish within %0d cycles", reset_cycles + num_rounds * 40);
    $display(">>> FAIL");
    $fatal(1);
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    rst_n     = 1'b0;
    in_valid  = '0;
    in_data   = '0;
    out_ready = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n     <= 1'b1;
    out_ready <= 1'b1;

    // Idle after reset
    repeat (2) @(posedge clk);
    check_value("out_valid", 64'(out_valid), 64'd0);
    check_value("in_ready", 64'(in_ready), 64'd0);

    // Four single forwards
    for (int i = 0; i < num_routes; i++) begin
      assign_group(route_mask_t'(1 << i), op_forward);
    end
    run_round();
    // Two LSB-AND pairs
    assign_group(4'b0011, op_lsb_and);
    assign_group(4'b1100, op_lsb_and);
    run_round();
    assign_group(4'b1111, op_lsb_and);
    run_round();
    assign_group(4'b0111, op_collect_b);
    assign_group(4'b1000, op_forward);
    run_round();
    // Interleaved groups
    assign_group(4'b0101, op_collect_b);
    assign_group(4'b1010, op_lsb_and);
    run_round();
    assign_group(4'b1111, op_collect_b);
    run_round();

    // Random groups with back-pressure
    random_ready = 1'b1;
    for (int n = 0; n < random_rounds; n++) begin
      pick_random_groups();
      run_round();
    end

    // Drain the output stage
    random_ready = 1'b0;
    out_ready <= 1'b1;
    drain_cycles = 0;
    while (exp_q.size() != 0 && drain_cycles < drain_cycles_max) begin
      @(posedge clk);
      drain_cycles++;
    end
    @(posedge clk);

    if (exp_q.size() == 0) begin
      check_value("out_valid", 64'(out_valid), 64'd0);
      $display(">>> PASS");
      $finish;
    end else begin
      $display("%0d expected flits never came out", exp_q.size());
      $display(">>> FAIL");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
red_pkg.sv
reduction_sync.sv
reduction_arbiter.sv
reduction_out_reg.sv
reduction_unit.sv
tb_reduction_unit.sv

//--- Makefile
# Verilator build for the reduction unit testbench

TOP = tb_reduction_unit

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f

# Run, show the output, and pass only if the pass line is seen
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
